/* Makefile */
# Verilator build and run of the TLP transmit testbench

SRCS := $(shell grep -v '^+' build.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_top: build.f $(SRCS)
	verilator --binary --timing --top-module tb_top -f build.f -o Vtb_top

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top | tee sim.log
	@if grep -q "Simulation failed" sim.log; then \
		echo "Run failed, see sim.log"; exit 1; \
	fi
	@if ! grep -q "Simulation passed" sim.log; then \
		echo "Run ended without a result, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* build.f */
src/tlp_pkg.sv
src/tx_link_out.sv
src/rd_tag_pool.sv
src/rd_req_gen.sv
src/wr_req_gen.sv
src/tlp_tx_arbiter.sv
src/tlp_tx_top.sv
tb/tb_top.sv

/* src/rd_req_gen.sv */
// Builds single-beat read TLPs from AFU read requests
// A request is taken only while a tag is free
`timescale 1ns/10ps

module rd_req_gen import tlp_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,

    input  logic      rd_req_valid,
    input  t_rd_req   rd_req,
    output logic      rd_req_ready,

    // Tag pool handshake
    input  logic      tag_free,
    output logic      tag_alloc,
    input  t_tag      alloc_tag,

    // To the arbiter
    output logic      beat_valid,
    output t_tlp_beat beat,
    input  logic      grant
);

    // Keeps ready low in the first cycle after reset
    logic started;

    // Room when empty or draining this cycle
    assign rd_req_ready = started && tag_free && (!beat_valid || grant);
    // Tag is claimed in the same cycle as the request
    assign tag_alloc    = rd_req_valid && rd_req_ready;

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            started    <= 1'b0;
            beat_valid <= 1'b0;
        end
        else
        begin
            started <= 1'b1;
            if (tag_alloc)
                beat_valid <= 1'b1;
            else if (grant)
                beat_valid <= 1'b0;
        end
    end

    // Header beat of the read TLP
    always_ff @(posedge clk)
    begin
        if (tag_alloc)
        begin
            beat.kind       <= TLP_MRD;
            beat.sop        <= 1'b1;
            beat.eop        <= 1'b1;
            beat.tag        <= alloc_tag;
            beat.addr       <= rd_req.addr;
            beat.line_count <= rd_req.line_count;
            beat.data       <= '0;
        end
    end

endmodule

/* src/rd_tag_pool.sv */
// Read tag free list with the tag to request id table
// A completion for a tag that is not busy is not detected
`timescale 1ns/10ps

module rd_tag_pool import tlp_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,

    // Allocation side, from the read generator
    input  logic    tag_alloc,
    input  t_req_id alloc_id,
    output logic    tag_free,
    output t_tag    alloc_tag,

    // Host completions
    input  logic    cpl_valid,
    input  t_tag    cpl_tag,

    // Read responses to the AFU
    output logic    rd_rsp_valid,
    output t_req_id rd_rsp_id
);

    // One bit per outstanding tag
    logic [TAG_COUNT-1:0] busy;
    // Request id of each outstanding tag
    t_req_id              id_table [TAG_COUNT];

    // ==============================
    // Free tag pick
    // ==============================
    assign tag_free = ~&busy;

    // Lowest free tag wins
    always_comb
    begin
        alloc_tag = '0;
        for (int i = TAG_COUNT - 1; i >= 0; i--)
        begin
            if (!busy[i])
                alloc_tag = t_tag'(i);
        end
    end

    // ==============================
    // Busy vector and response
    // ==============================
    // Alloc and free never hit the same tag in one cycle
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            busy         <= '0;
            rd_rsp_valid <= 1'b0;
        end
        else
        begin
            if (cpl_valid)
                busy[cpl_tag] <= 1'b0;
            if (tag_alloc)
                busy[alloc_tag] <= 1'b1;
            rd_rsp_valid <= cpl_valid;
        end
    end

    // Id written at allocation, looked up by the completion
    always_ff @(posedge clk)
    begin
        if (tag_alloc)
            id_table[alloc_tag] <= alloc_id;
        if (cpl_valid)
            rd_rsp_id <= id_table[cpl_tag];
    end

endmodule

/* src/tlp_pkg.sv */
// Shared sizes and types for the TLP transmit path
// Sizes are fixed here and the RTL has no module parameters
package tlp_pkg;

    // ==============================
    // Sizes
    // ==============================
    localparam int unsigned TAG_COUNT   = 8;
    localparam int unsigned TAG_W       = $clog2(TAG_COUNT);
    localparam int unsigned TX_CREDITS  = 4;
    // Longest write packet in lines
    localparam int unsigned MAX_LINES   = 4;
    localparam int unsigned ARB_CLIENTS = 3;

    // ==============================
    // Vector types
    // ==============================
    typedef logic [TAG_W-1:0]                   t_tag;
    typedef logic [7:0]                         t_req_id;
    typedef logic [31:0]                        t_addr;
    typedef logic [63:0]                        t_line;
    typedef logic [$clog2(MAX_LINES+1)-1:0]     t_line_count;
    typedef logic [$clog2(TX_CREDITS+1)-1:0]    t_credit_count;
    typedef logic [1:0]                         t_client_idx;

    // Arbiter client slots
    localparam t_client_idx CLIENT_MMIO = 2'd0;
    localparam t_client_idx CLIENT_RD   = 2'd1;
    localparam t_client_idx CLIENT_WR   = 2'd2;

    // ==============================
    // Enums and structs
    // ==============================
    typedef enum logic [1:0] {
        TLP_MRD,
        TLP_MWR,
        TLP_CPLD
    } t_tlp_kind;

    typedef enum logic [1:0] {
        ARB_NONE,
        ARB_LOCK_WR,
        ARB_LOCK_MMIO
    } t_arb_state;

    // Header fields only meaningful on the sop beat
    typedef struct packed {
        t_tlp_kind   kind;
        logic        sop;
        logic        eop;
        // Read tag, or host tag for a completion
        t_tag        tag;
        t_addr       addr;
        t_line_count line_count;
        t_line       data;
    } t_tlp_beat;

    typedef struct packed {
        t_req_id     id;
        t_addr       addr;
        t_line_count line_count;
    } t_rd_req;

    typedef struct packed {
        t_req_id     id;
        t_addr       addr;
        t_line_count line_count;
        logic        sop;
        logic        eop;
        t_line       data;
    } t_wr_line;

    // Always a single beat
    typedef struct packed {
        t_tag        tag;
        t_addr       addr;
        t_line       data;
    } t_mmio_rsp;

endpackage

/* src/tlp_tx_arbiter.sv */
// Round-robin arbiter of MMIO completions, reads and writes onto one TLP stream
// Grants are combinational and need credit_ok; a write holds the grant until eop
`timescale 1ns/10ps

module tlp_tx_arbiter import tlp_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,

    input  logic      mmio_valid,
    input  t_mmio_rsp mmio,
    output logic      mmio_grant,

    input  logic      rd_valid,
    input  t_tlp_beat rd_beat,
    output logic      rd_grant,

    input  logic      wr_valid,
    input  t_tlp_beat wr_beat,
    output logic      wr_grant,

    // Low while every read tag is busy
    input  logic      tag_free,
    input  logic      credit_ok,

    output logic      out_valid,
    output t_tlp_beat out_beat
);

    t_arb_state             arb_state;
    // Client with highest priority in the next open round
    t_client_idx            rr_ptr;
    t_client_idx            rr_next;
    logic [ARB_CLIENTS-1:0] req;
    logic [ARB_CLIENTS-1:0] pick;
    logic [ARB_CLIENTS-1:0] grant;
    t_tlp_beat              mmio_beat;

    // ==============================
    // Requests
    // ==============================
    assign req[CLIENT_MMIO] = mmio_valid;
    assign req[CLIENT_RD]   = rd_valid;
    // Hold writes back while reads are starved of tags
    assign req[CLIENT_WR]   = wr_valid && tag_free;

    // Rotating priority search starting at rr_ptr
    always_comb
    begin
        int unsigned idx;
        pick    = '0;
        rr_next = rr_ptr;
        for (int unsigned i = 0; i < ARB_CLIENTS; i++)
        begin
            idx = (32'(rr_ptr) + i) % ARB_CLIENTS;
            if ((pick == '0) && req[idx])
            begin
                pick[idx] = 1'b1;
                rr_next   = t_client_idx'((idx + 1) % ARB_CLIENTS);
            end
        end
    end

    // A locked write bypasses the round-robin pick
    always_comb
    begin
        grant = '0;
        if (credit_ok)
        begin
            case (arb_state)
                ARB_LOCK_WR: grant[CLIENT_WR] = wr_valid;
                default:     grant            = pick;
            endcase
        end
    end

    assign mmio_grant = grant[CLIENT_MMIO];
    assign rd_grant   = grant[CLIENT_RD];
    assign wr_grant   = grant[CLIENT_WR];
    assign out_valid  = |grant;

    // ==============================
    // Output beat
    // ==============================
    // MMIO response becomes a one-line completion
    always_comb
    begin
        mmio_beat.kind       = TLP_CPLD;
        mmio_beat.sop        = 1'b1;
        mmio_beat.eop        = 1'b1;
        mmio_beat.tag        = mmio.tag;
        mmio_beat.addr       = mmio.addr;
        mmio_beat.line_count = t_line_count'(1);
        mmio_beat.data       = mmio.data;
    end

    always_comb
    begin
        if (grant[CLIENT_MMIO])
            out_beat = mmio_beat;
        else if (grant[CLIENT_RD])
            out_beat = rd_beat;
        else
            out_beat = wr_beat;
    end

    // Lock from a granted non-eop beat until the eop beat goes out
    // Only a write beat can lack eop
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            arb_state <= ARB_NONE;
            rr_ptr    <= CLIENT_MMIO;
        end
        else if (out_valid)
        begin
            if (arb_state == ARB_NONE)
                rr_ptr <= rr_next;
            if (!out_beat.eop)
                arb_state <= ARB_LOCK_WR;
            else
                arb_state <= ARB_NONE;
        end
    end

endmodule

/* src/tlp_tx_top.sv */
// Transmit side of the host channel, three sources onto one credited TLP link
// Read completions carry only a tag, read data is not returned
`timescale 1ns/10ps

module tlp_tx_top import tlp_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,

    // AFU read requests
    input  logic      rd_req_valid,
    input  t_rd_req   rd_req,
    output logic      rd_req_ready,

    // AFU write lines
    input  logic      wr_line_valid,
    input  t_wr_line  wr_line,
    output logic      wr_line_ready,

    // AFU MMIO completions
    input  logic      mmio_rsp_valid,
    input  t_mmio_rsp mmio_rsp,
    output logic      mmio_rsp_ready,

    // Host completion tags, no back-pressure
    input  logic      cpl_valid,
    input  t_tag      cpl_tag,

    // Outbound link
    input  logic      credit_return,
    output logic      tx_valid,
    output t_tlp_beat tx_beat,

    // Responses to the AFU
    output logic      rd_rsp_valid,
    output t_req_id   rd_rsp_id,
    output logic      wr_rsp_valid,
    output t_req_id   wr_rsp_id
);

    // Read path
    logic      rd_beat_valid;
    t_tlp_beat rd_beat;
    logic      rd_grant;
    logic      tag_free;
    logic      tag_alloc;
    t_tag      alloc_tag;

    // Write path
    logic      wr_beat_valid;
    t_tlp_beat wr_beat;
    logic      wr_grant;

    // Arbiter to link stage
    logic      arb_valid;
    t_tlp_beat arb_beat;
    logic      credit_ok;

    // ==============================
    // Sources
    // ==============================
    rd_req_gen i_rd_req_gen (
        .clk          (clk),
        .reset_n      (reset_n),
        .rd_req_valid (rd_req_valid),
        .rd_req       (rd_req),
        .rd_req_ready (rd_req_ready),
        .tag_free     (tag_free),
        .tag_alloc    (tag_alloc),
        .alloc_tag    (alloc_tag),
        .beat_valid   (rd_beat_valid),
        .beat         (rd_beat),
        .grant        (rd_grant)
    );

    // Request id is stored against the tag at allocation
    rd_tag_pool i_rd_tag_pool (
        .clk          (clk),
        .reset_n      (reset_n),
        .tag_alloc    (tag_alloc),
        .alloc_id     (rd_req.id),
        .tag_free     (tag_free),
        .alloc_tag    (alloc_tag),
        .cpl_valid    (cpl_valid),
        .cpl_tag      (cpl_tag),
        .rd_rsp_valid (rd_rsp_valid),
        .rd_rsp_id    (rd_rsp_id)
    );

    wr_req_gen i_wr_req_gen (
        .clk           (clk),
        .reset_n       (reset_n),
        .wr_line_valid (wr_line_valid),
        .wr_line       (wr_line),
        .wr_line_ready (wr_line_ready),
        .beat_valid    (wr_beat_valid),
        .beat          (wr_beat),
        .grant         (wr_grant),
        .wr_rsp_valid  (wr_rsp_valid),
        .wr_rsp_id     (wr_rsp_id)
    );

    // ==============================
    // Arbitration and link
    // ==============================
    // MMIO ready is the arbiter grant itself
    tlp_tx_arbiter i_tlp_tx_arbiter (
        .clk        (clk),
        .reset_n    (reset_n),
        .mmio_valid (mmio_rsp_valid),
        .mmio       (mmio_rsp),
        .mmio_grant (mmio_rsp_ready),
        .rd_valid   (rd_beat_valid),
        .rd_beat    (rd_beat),
        .rd_grant   (rd_grant),
        .wr_valid   (wr_beat_valid),
        .wr_beat    (wr_beat),
        .wr_grant   (wr_grant),
        .tag_free   (tag_free),
        .credit_ok  (credit_ok),
        .out_valid  (arb_valid),
        .out_beat   (arb_beat)
    );

    tx_link_out i_tx_link_out (
        .clk           (clk),
        .reset_n       (reset_n),
        .in_valid      (arb_valid),
        .in_beat       (arb_beat),
        .credit_return (credit_return),
        .credit_ok     (credit_ok),
        .tx_valid      (tx_valid),
        .tx_beat       (tx_beat)
    );

endmodule

/* src/tx_link_out.sv */
// Registered link output with credit-based flow control
// The link must never return more credits than beats it was sent
`timescale 1ns/10ps

module tx_link_out import tlp_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,

    // Granted beat from the arbiter
    input  logic      in_valid,
    input  t_tlp_beat in_beat,

    // One pulse per freed beat slot
    input  logic      credit_return,
    output logic      credit_ok,

    output logic      tx_valid,
    output t_tlp_beat tx_beat
);

    t_credit_count credit_count;
    // Blocks grants in the first cycle after reset
    logic          link_up;

    assign credit_ok = link_up && (credit_count != '0);

    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            link_up      <= 1'b0;
            tx_valid     <= 1'b0;
            credit_count <= t_credit_count'(TX_CREDITS);
        end
        else
        begin
            link_up  <= 1'b1;
            tx_valid <= in_valid;
            // Send and return in one cycle cancel out
            case ({in_valid, credit_return})
                2'b10:   credit_count <= credit_count - 1'b1;
                2'b01:   credit_count <= credit_count + 1'b1;
                default: credit_count <= credit_count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
            tx_beat <= in_beat;
    end

endmodule

/* src/wr_req_gen.sv */
// Registers AFU write lines as write TLP beats and returns write responses
// Lines must arrive as complete sop to eop packets
`timescale 1ns/10ps

module wr_req_gen import tlp_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,

    input  logic      wr_line_valid,
    input  t_wr_line  wr_line,
    output logic      wr_line_ready,

    // To the arbiter
    output logic      beat_valid,
    output t_tlp_beat beat,
    input  logic      grant,

    // Write responses to the AFU
    output logic      wr_rsp_valid,
    output t_req_id   wr_rsp_id
);

    logic    started;
    logic    line_accept;
    // Id of the packet now in the output register
    t_req_id pkt_id;

    assign wr_line_ready = started && (!beat_valid || grant);
    assign line_accept   = wr_line_valid && wr_line_ready;

    // ==============================
    // Control
    // ==============================
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            started      <= 1'b0;
            beat_valid   <= 1'b0;
            wr_rsp_valid <= 1'b0;
        end
        else
        begin
            started <= 1'b1;
            if (line_accept)
                beat_valid <= 1'b1;
            else if (grant)
                beat_valid <= 1'b0;
            // Response follows the granted eop by one cycle
            wr_rsp_valid <= grant && beat.eop;
        end
    end

    // ==============================
    // Payload
    // ==============================
    always_ff @(posedge clk)
    begin
        if (line_accept)
        begin
            beat.kind       <= TLP_MWR;
            beat.sop        <= wr_line.sop;
            beat.eop        <= wr_line.eop;
            beat.tag        <= '0;
            beat.addr       <= wr_line.addr;
            beat.line_count <= wr_line.line_count;
            beat.data       <= wr_line.data;
        end
        // New sop may load while the old eop is granted
        if (line_accept && wr_line.sop)
            pkt_id <= wr_line.id;
        if (grant && beat.eop)
            wr_rsp_id <= pkt_id;
    end

endmodule

/* tb/tb_top.sv */
// Testbench for tlp_tx_top driven by records from tb/tlp_testdata.hex
// Must be run from the project root; reset_n is high while reset is asserted
`timescale 1ns/10ps

module tb_top import tlp_pkg::*;
();

    typedef struct packed {
        logic [3:0]  kind;
        t_req_id     id;
        t_addr       addr;
        logic [3:0]  count;
        logic [15:0] seed;
    } t_record;

    logic clk = 1'b0;
    logic reset_n;
    logic rd_req_valid, wr_line_valid, mmio_rsp_valid, cpl_valid, credit_return;
    logic rd_req_ready, wr_line_ready, mmio_rsp_ready, tx_valid, rd_rsp_valid, wr_rsp_valid;
    t_rd_req   rd_req;
    t_wr_line  wr_line;
    t_mmio_rsp mmio_rsp;
    t_tag      cpl_tag;
    t_tlp_beat tx_beat;
    t_req_id   rd_rsp_id, wr_rsp_id;

    logic [63:0] mem [0:31];
    int          num_records;
    int          timeout_limit = 100000;
    int          cycle = 0;
    logic [31:0] lfsr_state = 32'h1f65_dc41;

    // Per-source stimulus and expected queues
    t_record   rd_q[$], wr_q[$], mmio_q[$];
    t_tlp_beat exp_rd[$], exp_wr[$], exp_mmio[$];
    t_req_id   exp_rd_id[$], exp_wr_id[$], exp_rd_rsp[$], exp_wr_rsp[$];
    // Link and tag tracking
    t_tag      cpl_pending[$];
    logic [TAG_COUNT-1:0] tag_busy = '0;
    t_req_id   tag_id [TAG_COUNT];
    int        outstanding = 0;
    int        sent = 0;
    int        returned = 0;
    int        cpl_wait = 0;
    int        after_reset = 0;
    logic      hold_cpl = 1'b0;
    logic      in_write = 1'b0;

    tlp_tx_top i_dut (.*);

    always #5 clk = ~clk;

    // ==============================
    // Helpers
    // ==============================
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    endtask

    // Data of line i of a record
    function automatic t_line line_data(t_record r, int i);
        return {r.seed, 16'(i), r.addr + 32'(i * 8)};
    endfunction

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_beat(string name, t_tlp_beat got, t_tlp_beat exp);
        if (got !== exp)
            fail_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_rd_rsp(t_req_id got, t_req_id exp);
        if (got !== exp)
            fail_run($sformatf("FAIL rd_rsp_id got %h expected %h", got, exp));
    endtask

    task automatic check_wr_rsp(t_req_id got, t_req_id exp);
        if (got !== exp)
            fail_run($sformatf("FAIL wr_rsp_id got %h expected %h", got, exp));
    endtask

    // ==============================
    // Source drivers
    // ==============================
    initial
    begin
        t_record r;
        forever
        begin
            @(posedge clk);
            if (rd_q.size() != 0)
            begin
                r = rd_q.pop_front();
                exp_rd.push_back({TLP_MRD, 1'b1, 1'b1, t_tag'(0), r.addr,
                                  t_line_count'(r.count), t_line'(0)});
                exp_rd_id.push_back(r.id);
                rd_req_valid <= 1'b1;
                rd_req       <= {r.id, r.addr, t_line_count'(r.count)};
                do @(negedge clk); while (!rd_req_ready);
                @(posedge clk);
                rd_req_valid <= 1'b0;
            end
        end
    end

    initial
    begin
        t_record r;
        t_wr_line l;
        forever
        begin
            @(posedge clk);
            if (wr_q.size() != 0)
            begin
                r = wr_q.pop_front();
                exp_wr_id.push_back(r.id);
                for (int i = 0; i < int'(r.count); i++)
                begin
                    l = {r.id, r.addr, t_line_count'(r.count), i == 0,
                         i == int'(r.count) - 1, line_data(r, i)};
                    exp_wr.push_back({TLP_MWR, l.sop, l.eop, t_tag'(0), r.addr,
                                      t_line_count'(r.count), l.data});
                    wr_line_valid <= 1'b1;
                    wr_line       <= l;
                    do @(negedge clk); while (!wr_line_ready);
                    @(posedge clk);
                end
                wr_line_valid <= 1'b0;
            end
        end
    end

    initial
    begin
        t_record r;
        forever
        begin
            @(posedge clk);
            if (mmio_q.size() != 0)
            begin
                r = mmio_q.pop_front();
                exp_mmio.push_back({TLP_CPLD, 1'b1, 1'b1, t_tag'(r.id), r.addr,
                                    t_line_count'(1), line_data(r, 0)});
                mmio_rsp_valid <= 1'b1;
                mmio_rsp       <= {t_tag'(r.id), r.addr, line_data(r, 0)};
                do @(negedge clk); while (!mmio_rsp_ready);
                @(posedge clk);
                mmio_rsp_valid <= 1'b0;
            end
        end
    end

    // ==============================
    // Link credits and host completions
    // ==============================
    always @(posedge clk)
    begin
        logic b;
        logic [2:0] d;
        cycle = cycle + 1;
        if (cycle > timeout_limit)
            fail_run("Timeout, the run did not finish within the cycle limit");
        take_bit(b);
        // Credit only for a beat the link holds
        if (!reset_n && (sent - returned > 0) && b)
        begin
            credit_return <= 1'b1;
            returned = returned + 1;
        end
        else
            credit_return <= 1'b0;
        cpl_valid <= 1'b0;
        if (!hold_cpl && cpl_pending.size() != 0)
        begin
            if (cpl_wait == 0)
            begin
                cpl_tag   <= cpl_pending[0];
                cpl_valid <= 1'b1;
                exp_rd_rsp.push_back(tag_id[cpl_pending[0]]);
                tag_busy[cpl_pending[0]] = 1'b0;
                void'(cpl_pending.pop_front());
                outstanding = outstanding - 1;
                for (int i = 0; i < 3; i++)
                begin
                    take_bit(b);
                    d[i] = b;
                end
                cpl_wait = int'(d);
            end
            else
                cpl_wait = cpl_wait - 1;
        end
    end

    // ==============================
    // Output monitor
    // ==============================
    always @(negedge clk)
    begin
        t_tlp_beat e;
        // Valids low in reset and the first cycle after it
        if (reset_n || after_reset < 2)
        begin
            if (tx_valid || rd_rsp_valid || wr_rsp_valid)
                fail_run("An output valid was high during or right after reset");
        end
        if (!reset_n)
            after_reset = after_reset + 1;
        if (tx_valid)
        begin
            sent = sent + 1;
            if (sent - returned > int'(TX_CREDITS))
                fail_run("More beats in flight on the link than credits allow");
            if (in_write && tx_beat.kind != TLP_MWR)
                fail_run("Another source's beat came inside a write packet");
            case (tx_beat.kind)
                TLP_MRD:
                begin
                    if (exp_rd.size() == 0)
                        fail_run("Unexpected read TLP on the link");
                    if (outstanding >= int'(TAG_COUNT))
                        fail_run("More reads outstanding than there are tags");
                    if (tag_busy[tx_beat.tag])
                        fail_run("Read TLP used a tag that is still outstanding");
                    e = exp_rd.pop_front();
                    e.tag = tx_beat.tag;
                    check_beat("tx_beat", tx_beat, e);
                    tag_busy[tx_beat.tag] = 1'b1;
                    tag_id[tx_beat.tag] = exp_rd_id.pop_front();
                    outstanding = outstanding + 1;
                    cpl_pending.push_back(tx_beat.tag);
                end
                TLP_MWR:
                begin
                    if (exp_wr.size() == 0)
                        fail_run("Unexpected write TLP on the link");
                    // Writes are held back while every tag is busy
                    if (tx_beat.sop && outstanding == int'(TAG_COUNT))
                        fail_run("A write packet started while all read tags were busy");
                    check_beat("tx_beat", tx_beat, exp_wr.pop_front());
                    in_write = !tx_beat.eop;
                    if (tx_beat.eop)
                        exp_wr_rsp.push_back(exp_wr_id.pop_front());
                end
                default:
                begin
                    if (exp_mmio.size() == 0)
                        fail_run("Unexpected completion TLP on the link");
                    check_beat("tx_beat", tx_beat, exp_mmio.pop_front());
                end
            endcase
        end
        if (rd_rsp_valid)
        begin
            if (exp_rd_rsp.size() == 0)
                fail_run("Read response without a completion");
            check_rd_rsp(rd_rsp_id, exp_rd_rsp.pop_front());
        end
        if (wr_rsp_valid)
        begin
            if (exp_wr_rsp.size() == 0)
                fail_run("Write response without a finished write");
            check_wr_rsp(wr_rsp_id, exp_wr_rsp.pop_front());
        end
    end

    // ==============================
    // Record dispatch
    // ==============================
    function automatic logic drained();
        return rd_q.size() == 0 && wr_q.size() == 0 && mmio_q.size() == 0 &&
               exp_rd.size() == 0 && exp_wr.size() == 0 && exp_mmio.size() == 0 &&
               exp_rd_rsp.size() == 0 && exp_wr_rsp.size() == 0 &&
               cpl_pending.size() == 0 && outstanding == 0 &&
               !rd_req_valid && !wr_line_valid && !mmio_rsp_valid;
    endfunction

    initial
    begin
        reset_n = 1'b1;
        repeat (10) @(posedge clk);
        reset_n <= 1'b0;
    end

    initial
    begin
        t_record r;
        rd_req_valid   = 1'b0;
        wr_line_valid  = 1'b0;
        mmio_rsp_valid = 1'b0;
        cpl_valid      = 1'b0;
        credit_return  = 1'b0;
        rd_req         = '0;
        wr_line        = '0;
        mmio_rsp       = '0;
        cpl_tag        = '0;
        // Unused words read as kind f
        for (int i = 0; i < 32; i++)
            mem[i] = {4'hf, 60'(i)};
        $readmemh("tb/tlp_testdata.hex", mem);
        num_records = 0;
        while (num_records < 32 && mem[num_records][63:60] != 4'hf)
            num_records++;
        timeout_limit = 200 * num_records;
        // Sources start while reset is still asserted
        for (int n = 0; n < num_records; n++)
        begin
            @(negedge clk);
            r = t_record'(mem[n]);
            case (r.kind)
                4'h0: rd_q.push_back(r);
                4'h1: wr_q.push_back(r);
                4'h2: mmio_q.push_back(r);
                4'h3: hold_cpl = 1'b1;
                default:
                begin
                    // Fill the pool, then all new reads must stall
                    while (outstanding != int'(TAG_COUNT) &&
                           !(rd_q.size() == 0 && !rd_req_valid))
                        @(negedge clk);
                    // A write offered now has to wait for a free tag
                    if (n + 1 < num_records)
                    begin
                        r = t_record'(mem[n + 1]);
                        if (r.kind == 4'h1)
                        begin
                            wr_q.push_back(r);
                            n++;
                        end
                    end
                    repeat (20)
                    begin
                        @(negedge clk);
                        if (outstanding == int'(TAG_COUNT) && rd_req_ready)
                            fail_run("Read request taken while no tag was free");
                    end
                    hold_cpl = 1'b0;
                end
            endcase
        end
        while (!drained())
            @(negedge clk);
        repeat (10) @(negedge clk);
        if (drained() && !in_write)
        begin
            $display("Simulation passed");
            $finish;
        end
        else
            fail_run("Extra activity after all records were done");
    end

endmodule

/* tb/tlp_testdata.hex */
// kind(0 rd, 1 wr, 2 mmio, 3 hold cpl, 4 release cpl) _ id _ addr _ lines _ data seed
// Run from the project root, one record per line
0_01_00001000_1_0000
1_02_00002000_3_a1b2
2_03_00003000_1_c3d4
0_04_00001040_2_0000
2_05_00003008_1_1234
1_06_00002100_4_5678
0_07_00001080_1_0000
3_00_00000000_0_0000
0_10_00004000_1_0000
0_11_00004040_2_0000
1_12_00002200_2_9abc
0_13_00004080_4_0000
0_14_000040c0_1_0000
0_15_00004100_3_0000
2_16_00003010_1_def0
0_17_00004140_1_0000
0_18_00004180_2_0000
0_19_000041c0_1_0000
4_00_00000000_0_0000
1_20_00002300_1_0f0f
2_21_00003018_1_7777
0_22_00004200_1_0000
